// ==== bench/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // release on a falling edge, away from the capture edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== bench/tb_rs_encoder.sv ====
`default_nettype none

`include "rs_config.svh"

module tb_rs_encoder;
    timeunit 1ns;
    timeprecision 1ps;

    import rs_pkg::*;

    localparam int RAND_SEED        = 88435;
    localparam int SETTLE_NS        = 2;        // after the falling edge drive
    localparam int FRAME_CYCLES_MAX = 400;      // one frame with its worst stalls
    localparam int NUM_FRAMES       = 6;
    // frames plus headroom for reset, idle cycles and the cut frame
    localparam int MAX_CYCLES       = (NUM_FRAMES + 4) * FRAME_CYCLES_MAX;
    localparam int MAX_GAP_CYCLES   = 140;      // keeps the stalled frame under the bound
    localparam int PROD_W           = 2 * `RS_SYM_W - 1;

    typedef logic [PROD_W-1:0] prod_t;

    logic       clk;
    logic       por_rst_n;
    logic       test_rst_n;
    logic       rst_n;
    rs_stream_t stim;               // driven symbol and its strobes
    rs_sym_t    din;
    logic       din_en;
    logic       din_syn;
    rs_sym_t    dout;
    logic       dout_en;
    logic       dout_syn;

    string      cur_test;
    int         test_errors;
    int         tests_passed;
    int         tests_failed;
    int         cycle_count;

    rs_sym_t    frame_data [`RS_K];
    rs_sym_t    parity     [`RS_NPAR];  // parity[0] leaves first

    // ------------------------------
    // clock, reset and DUT
    // ------------------------------

    tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(4)) u_clock_gen (
        .clk   (clk),
        .rst_n (por_rst_n)
    );

    assign rst_n   = por_rst_n && test_rst_n;
    assign din     = stim.sym;
    assign din_en  = stim.en;
    assign din_syn = stim.syn;

    rs_encoder i_rs_encoder (
        .clk      (clk),
        .rst_n    (rst_n),
        .din      (din),
        .din_en   (din_en),
        .din_syn  (din_syn),
        .dout     (dout),
        .dout_en  (dout_en),
        .dout_syn (dout_syn)
    );

    // strobes are pure mirrors in every cycle including reset
    en_mirror: assert property (@(posedge clk) dout_en == din_en)
        else begin
            $display("Fail %s expected dout_en %b actual %b", cur_test, din_en, dout_en);
            test_errors++;
        end

    syn_mirror: assert property (@(posedge clk) dout_syn == din_syn)
        else begin
            $display("Fail %s expected dout_syn %b actual %b", cur_test, din_syn, dout_syn);
            test_errors++;
        end

    // ------------------------------
    // reference model
    // ------------------------------

    function automatic rs_sym_t field_mult(input rs_sym_t a, input rs_sym_t b);
        prod_t   prod;
        prod_t   mask;
        rs_sym_t b_rest;
        prod   = '0;
        b_rest = b;
        for (int i = 0; i < `RS_SYM_W; i++) begin
            if (b_rest[0]) begin
                prod = prod ^ (prod_t'(a) << i);    // carry-less product
            end
            b_rest = b_rest >> 1;
        end
        // reduce modulo the field polynomial from the top degree down
        for (int j = PROD_W - 1; j >= `RS_SYM_W; j--) begin
            mask = prod_t'(1) << j;
            if ((prod & mask) != '0) begin
                prod = prod ^ (prod_t'(`RS_PRIM_POLY) << (j - `RS_SYM_W));
            end
        end
        return prod[`RS_SYM_W-1:0];
    endfunction

    // remainder of m(x) * x^32 by g(x) one data symbol at a time
    task automatic compute_parity();
        rs_sym_t rem [`RS_NPAR];
        rs_sym_t fb;
        for (int i = 0; i < `RS_NPAR; i++) begin
            rem[i] = '0;
        end
        for (int k = 0; k < `RS_K; k++) begin
            fb = frame_data[k] ^ rem[`RS_NPAR-1];
            for (int i = `RS_NPAR - 1; i > 0; i--) begin
                rem[i] = rem[i-1] ^ field_mult(fb, gen_coeff[i]);
            end
            rem[0] = field_mult(fb, gen_coeff[0]);
        end
        for (int i = 0; i < `RS_NPAR; i++) begin
            parity[i] = rem[`RS_NPAR-1-i];      // highest degree goes out first
        end
    endtask

    // ------------------------------
    // stimulus and checks
    // ------------------------------

    task automatic fill_frame(input bit zeros);
        for (int k = 0; k < `RS_K; k++) begin
            frame_data[k] = zeros ? '0 : rs_sym_t'($urandom);
        end
    endtask

    task automatic drive_idle();
        @(negedge clk);
        stim.sym = rs_sym_t'($urandom);         // don't-care while en is low
        stim.en  = 1'b0;
        stim.syn = 1'b0;
    endtask

    task automatic drive_symbol(input rs_sym_t sym, input logic syn);
        @(negedge clk);
        stim.sym = sym;
        stim.en  = 1'b1;
        stim.syn = syn;
    endtask

    task automatic check_strobes();
        assert (dout_en === stim.en && dout_syn === stim.syn) else begin
            $display("Fail %s expected en/syn %b%b actual %b%b", cur_test,
                     stim.en, stim.syn, dout_en, dout_syn);
            test_errors++;
        end
    endtask

    task automatic check_symbol(input rs_sym_t expected, input int pos);
        check_strobes();
        assert (dout === expected) else begin
            $display("Fail %s expected %02h actual %02h at position %0d", cur_test,
                     expected, dout, pos);
            test_errors++;
        end
    endtask

    // n_sym below RS_N cuts the frame short
    task automatic run_frame(input bit with_gaps, input int n_sym);
        int      gaps_used;
        int      gap;
        rs_sym_t sym;
        rs_sym_t expected;
        gaps_used = 0;
        compute_parity();
        for (int pos = 0; pos < n_sym; pos++) begin
            if (with_gaps && pos > 0 && gaps_used < MAX_GAP_CYCLES
                    && $urandom_range(3, 0) == 0) begin
                gap = $urandom_range(2, 1);
                for (int g = 0; g < gap; g++) begin
                    drive_idle();
                end
                gaps_used += gap;
            end
            if (pos < `RS_K) begin
                sym      = frame_data[pos];
                expected = sym;                                 // data echo
            end else begin
                sym      = rs_sym_t'($urandom);                 // ignored by the DUT
                expected = parity[pos - `RS_K];
            end
            drive_symbol(sym, pos == 0);
            #SETTLE_NS;
            check_symbol(expected, pos);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("[ok]   %s", cur_test);
            tests_passed++;
        end else begin
            $display("[bad]  %s, %0d mismatches", cur_test, test_errors);
            tests_failed++;
        end
    endtask

    // ------------------------------
    // watchdog
    // ------------------------------

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: %s did not finish within %0d cycles", cur_test, MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ------------------------------
    // test sequence
    // ------------------------------

    initial begin
        void'($urandom(RAND_SEED));
        stim         = '0;
        test_rst_n   = 1'b1;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count  = 0;

        // the reset window counts toward the first test
        start_test("strobe_mirror");
        wait (por_rst_n === 1'b1);
        drive_idle();

        // strobes with en low and state frozen
        for (int c = 0; c < 20; c++) begin
            @(negedge clk);
            stim.sym = rs_sym_t'($urandom);
            stim.en  = 1'b0;
            stim.syn = 1'($urandom_range(1, 0));
            #SETTLE_NS;
            check_strobes();
        end
        drive_idle();
        finish_test();

        start_test("random_frames");
        for (int f = 0; f < 3; f++) begin
            fill_frame(1'b0);
            run_frame(1'b0, `RS_N);     // back to back with no idle between
        end
        drive_idle();
        finish_test();

        start_test("zero_frame");
        fill_frame(1'b1);
        run_frame(1'b0, `RS_N);
        drive_idle();
        finish_test();

        start_test("stalled_frame");
        fill_frame(1'b0);
        run_frame(1'b1, `RS_N);
        drive_idle();
        finish_test();

        start_test("reset_recovery");
        fill_frame(1'b0);
        run_frame(1'b0, `RS_K + 10);    // stop ten symbols into the parity
        @(negedge clk);
        stim.en    = 1'b0;
        stim.syn   = 1'b0;
        test_rst_n = 1'b0;
        repeat (2) @(negedge clk);
        test_rst_n = 1'b1;
        drive_idle();
        fill_frame(1'b0);
        run_frame(1'b0, `RS_N);
        drive_idle();
        finish_test();

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/rs_pkg.sv
verilog/rs_symbol_counter.sv
verilog/rs_parity_lfsr.sv
verilog/rs_encoder.sv
bench/tb_clock_gen.sv
bench/tb_rs_encoder.sv

// ==== run.sh ====
#!/bin/sh
# build and run the RS(255,223) encoder testbench with Verilator
# exit status is 0 only when the log holds the pass line

cd "$(dirname "$0")" || exit 1

TOP=tb_rs_encoder
OBJ=obj_dir
LOG=sim.log

rm -f "$LOG"

echo "building $TOP"
verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" \
    -Mdir "$OBJ" -o "$TOP" \
    -f flist.f
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

echo "running simulation"
"./$OBJ/$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail, see $LOG"
    exit 1
fi

// ==== verilog/rs_config.svh ====
`ifndef RS_CONFIG_SVH
`define RS_CONFIG_SVH

// ------------------------------
// code geometry
// ------------------------------

// bits per symbol, GF(2^8)
`define RS_SYM_W 8

// symbols per codeword
`define RS_N 255

// data symbols per codeword, the rest is parity
`define RS_K 223

// parity symbols, equal to RS_N - RS_K and to the generator degree
`define RS_NPAR 32

// ------------------------------
// field
// ------------------------------

// x^8 + x^4 + x^3 + x^2 + 1
`define RS_PRIM_POLY 9'h11D

`endif

// ==== verilog/rs_encoder.sv ====
`default_nettype none

module rs_encoder (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire rs_pkg::rs_sym_t din,
    input  wire logic            din_en,      // symbol strobe
    input  wire logic            din_syn,     // first symbol of a codeword
    output rs_pkg::rs_sym_t      dout,
    output logic                 dout_en,
    output logic                 dout_syn
);

    import rs_pkg::*;

    rs_stream_t in_stream;
    rs_phase_e  phase;

    // ------------------------------
    // input bundle
    // ------------------------------

    always_comb begin
        in_stream.sym = din;
        in_stream.en  = din_en;
        in_stream.syn = din_syn;
    end

    // ------------------------------
    // position and phase
    // ------------------------------

    rs_symbol_counter u_counter (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_stream (in_stream),
        .phase     (phase)
    );

    // ------------------------------
    // division and output select
    // ------------------------------

    rs_parity_lfsr u_lfsr (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_stream (in_stream),
        .phase     (phase),
        .dout      (dout)
    );

    // zero latency, so the qualifiers go straight through
    assign dout_en  = din_en;
    assign dout_syn = din_syn;

endmodule

`default_nettype wire

// ==== verilog/rs_parity_lfsr.sv ====
`default_nettype none

`include "rs_config.svh"

module rs_parity_lfsr (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire rs_pkg::rs_stream_t in_stream,
    input  wire rs_pkg::rs_phase_e  phase,
    output rs_pkg::rs_sym_t         dout
);

    import rs_pkg::*;

    localparam int LAST = `RS_NPAR - 1;

    // stage i holds the coefficient of x^i of the running remainder
    rs_sym_t stage   [`RS_NPAR];
    rs_sym_t product [`RS_NPAR];
    rs_sym_t feedback;

    // ------------------------------
    // feedback
    // ------------------------------

    // in the data phase this is the quotient symbol of the division
    // in the parity phase the register only shifts, so no feedback
    always_comb begin
        if (phase == PHASE_DATA) begin
            feedback = in_stream.sym ^ stage[LAST];
        end else begin
            feedback = '0;
        end
    end

    // ------------------------------
    // constant multipliers
    // ------------------------------

    // one multiplier per generator coefficient
    for (genvar i = 0; i < `RS_NPAR; i++) begin : g_mul
        assign product[i] = gf_mul(feedback, gen_coeff[i]);
    end

    // ------------------------------
    // remainder register
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RS_NPAR; i++) begin
                stage[i] <= '0;
            end
        end else if (in_stream.en) begin
            stage[0] <= product[0];                         // no lower stage to add
            for (int i = 1; i < `RS_NPAR; i++) begin
                stage[i] <= stage[i-1] ^ product[i];
            end
        end
    end

    // after RS_K data shifts the register holds the parity, highest degree
    // in the last stage; the parity shifts then move it out one per symbol
    // and leave the register clear for the next frame

    // ------------------------------
    // output select
    // ------------------------------

    // systematic code: message first, then the remainder
    always_comb begin
        if (phase == PHASE_DATA) begin
            dout = in_stream.sym;
        end else begin
            dout = stage[LAST];     // parity symbol, top degree first
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rs_pkg.sv ====
`default_nettype none

`include "rs_config.svh"

package rs_pkg;

    // ------------------------------
    // basic types
    // ------------------------------

    typedef logic [`RS_SYM_W-1:0] rs_sym_t;            // one field element

    typedef logic [$clog2(`RS_N)-1:0] rs_pos_t;        // 0 .. RS_N-1

    // which half of the codeword the current symbol belongs to
    typedef enum logic {
        PHASE_DATA   = 1'b0,    // message symbols, echoed and divided
        PHASE_PARITY = 1'b1     // remainder shifted out
    } rs_phase_e;

    // input symbol together with its qualifiers
    typedef struct packed {
        rs_sym_t sym;
        logic    en;            // symbol valid this cycle
        logic    syn;           // first symbol of a codeword
    } rs_stream_t;

    // ------------------------------
    // generator polynomial
    // ------------------------------

    // g(x) = x^32 + g31 x^31 + ... + g1 x + g0, leading 1 is implicit
    // index is the register stage the product feeds
    localparam rs_sym_t gen_coeff [`RS_NPAR] = '{
        8'd45,  8'd216, 8'd239, 8'd24,      // g0  .. g3
        8'd253, 8'd104, 8'd27,  8'd40,      // g4  .. g7
        8'd107, 8'd50,  8'd163, 8'd210,     // g8  .. g11
        8'd227, 8'd134, 8'd224, 8'd158,     // g12 .. g15
        8'd119, 8'd13,  8'd158, 8'd1,       // g16 .. g19
        8'd238, 8'd164, 8'd82,  8'd43,      // g20 .. g23
        8'd15,  8'd232, 8'd246, 8'd142,     // g24 .. g27
        8'd50,  8'd189, 8'd29,  8'd232      // g28 .. g31
    };

    // reduction term once the x^8 bit is dropped
    localparam rs_sym_t PRIM_LOW = rs_sym_t'(`RS_PRIM_POLY);

    // ------------------------------
    // field arithmetic
    // ------------------------------

    // shift-and-add product of two field elements
    // with one constant operand this folds down to an xor network
    function automatic rs_sym_t gf_mul(input rs_sym_t a, input rs_sym_t b);
        rs_sym_t acc;
        rs_sym_t sh;
        logic    carry;
        acc = '0;
        sh  = a;                                       // a * x^i, already reduced
        for (int i = 0; i < `RS_SYM_W; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            carry = sh[`RS_SYM_W-1];
            sh    = sh << 1;
            if (carry) begin
                sh = sh ^ PRIM_LOW;                    // x^8 -> x^4 + x^3 + x^2 + 1
            end
        end
        return acc;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/rs_symbol_counter.sv ====
`default_nettype none

`include "rs_config.svh"

module rs_symbol_counter (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire rs_pkg::rs_stream_t in_stream,
    output rs_pkg::rs_phase_e       phase
);

    import rs_pkg::*;

    localparam rs_pos_t LAST_POS  = rs_pos_t'(`RS_N - 1);
    localparam rs_pos_t FIRST_PAR = rs_pos_t'(`RS_K);

    rs_pos_t count;         // position of the next enabled symbol
    rs_pos_t cur_pos;       // position of the symbol on the input now
    rs_pos_t next_pos;

    // ------------------------------
    // current position
    // ------------------------------

    // a sync always restarts the frame, even mid codeword
    assign cur_pos = in_stream.syn ? '0 : count;

    // wrap after the last parity symbol
    always_comb begin
        if (cur_pos == LAST_POS) begin
            next_pos = '0;
        end else begin
            next_pos = cur_pos + 1'b1;
        end
    end

    // ------------------------------
    // position register
    // ------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (in_stream.en) begin
            count <= next_pos;      // stalls hold the count
        end
    end

    // ------------------------------
    // phase decode
    // ------------------------------

    // positions 0 .. RS_K-1 carry data, the remaining RS_NPAR carry parity
    assign phase = (cur_pos < FIRST_PAR) ? PHASE_DATA : PHASE_PARITY;

endmodule

`default_nettype wire
